/* dv/spi_checker.sv */
`timescale 1ns/1ps

module spi_checker
(
  input  logic                 i_sys_clk,
  input  logic                 check_i,        // Compare on the next rising edge
  input  logic                 test_done_i,    // Close the current test
  input  logic [71:0]          name_i,         // Nine character test name
  input  spi_pkg::spi_status_t exp_status_i,
  input  logic                 data_care_i,
  input  spi_pkg::spi_word_t   exp_data_i,
  input  logic                 mosi_care_i,
  input  spi_pkg::spi_word_t   exp_mosi_i,
  input  spi_pkg::spi_word_t   got_mosi_i,     // Word the master sampled
  input  spi_pkg::spi_word_t   data_i,
  input  logic                 tx_ready_i,
  input  logic                 rx_ready_i,
  input  logic                 tx_error_i,
  input  logic                 rx_error_i,
  input  logic                 intr_i,
  input  logic                 mosi_i,
  input  logic                 mosi_tri_en_i,
  input  logic                 ssn_i,          // Select driven by the master
  output int                   tests_o,
  output int                   failed_o,
  output int                   errors_o
);

  import spi_pkg::*;

  spi_status_t seen;
  int          test_errors = 0;
  int          tests = 0;
  int          failed = 0;
  int          errors = 0;

  assign seen = '{tx_ready: tx_ready_i, rx_ready: rx_ready_i,
                  tx_error: tx_error_i, rx_error: rx_error_i};

  task automatic report(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s %s expected %0h got %0h", name_i, what, exp, act);
    test_errors++;
  endtask

  // DUT outputs are read before this edge's register updates land
  always @(posedge i_sys_clk)
  begin
    if (mosi_tri_en_i !== ssn_i)
      report("mosi_tri_en", 32'(ssn_i), 32'(mosi_tri_en_i));
    if (check_i)
    begin
      if (seen !== exp_status_i)
        report("status txr/rxr/txe/rxe", 32'(exp_status_i), 32'(seen));
      if (data_care_i && data_i !== exp_data_i)
        report("data_o", 32'(exp_data_i), 32'(data_i));
      if (mosi_care_i && got_mosi_i !== exp_mosi_i)
        report("mosi word", 32'(exp_mosi_i), 32'(got_mosi_i));
      if ({intr_i, mosi_i, mosi_tri_en_i} !== 3'b101)
        report("intr/mosi/tri_en", 32'(3'b101), 32'({intr_i, mosi_i, mosi_tri_en_i}));
    end
    if (test_done_i)
    begin
      tests++;
      errors = errors + test_errors;
      if (test_errors == 0)
        $display("%s: ok", name_i);
      else
      begin
        failed++;
        $display("%s: %0d mismatches", name_i, test_errors);
      end
      test_errors = 0;
    end
  end

  assign tests_o  = tests;
  assign failed_o = failed;
  assign errors_o = errors;

endmodule

/* dv/tb_spi_data_path.sv */
`timescale 1ns/1ps
`include "spi_settings.svh"

module tb_spi_data_path;

  import spi_pkg::*;

  localparam int ROWS        = 8;
  localparam int WAIT_LIMIT  = 50;                           // System cycles
  localparam int XFER_NS     = `SPI_DATA_SIZE * 24 + 200;
  localparam int WATCHDOG_NS = (ROWS + 2) * XFER_NS + 1000;  // Rows plus two overwrite transfers

  typedef struct packed {
    logic [71:0] name;
    logic        cpol;
    logic        cpha;
    logic        lsb_first;
    spi_word_t   tx_word;
    spi_word_t   rx_word;
  } stim_row_t;

  logic        i_sys_clk;
  logic        i_sys_rst;
  logic        csn;
  spi_word_t   wr_data;
  logic        wr;
  logic        rd;
  logic        spi_start;
  spi_word_t   rd_data;
  logic        tx_ready;
  logic        rx_ready;
  logic        tx_error;
  logic        rx_error;
  logic        cpol;
  logic        cpha;
  logic        lsb_first;
  logic        intr;
  logic        mosi;
  logic        miso;
  logic        ssn;
  logic        sclk;
  logic        mosi_tri_en;
  logic        check;
  logic        test_done;
  logic [71:0] cur_name;
  spi_status_t exp_status;
  logic        data_care;
  spi_word_t   exp_data;
  logic        mosi_care;
  spi_word_t   exp_mosi;
  spi_word_t   got_mosi;
  int          tests;
  int          failed;
  int          errors;
  int          timeouts = 0;
  logic [31:0] rng;
  stim_row_t   stim_rows [ROWS];

  spi_data_path dut_i (
    .i_sys_clk (i_sys_clk), .i_sys_rst (i_sys_rst), .csn_i (csn), .data_i (wr_data),
    .wr_i (wr), .rd_i (rd), .spi_start_i (spi_start), .data_o (rd_data),
    .tx_ready_o (tx_ready), .rx_ready_o (rx_ready), .tx_error_o (tx_error),
    .rx_error_o (rx_error), .cpol_i (cpol), .cpha_i (cpha), .lsb_first_i (lsb_first),
    .intr_o (intr), .mosi_o (mosi), .miso_i (miso), .ssn_i (ssn), .sclk_i (sclk),
    .mosi_tri_en_o (mosi_tri_en)
  );

  spi_checker monitor_i (
    .i_sys_clk (i_sys_clk), .check_i (check), .test_done_i (test_done), .name_i (cur_name),
    .exp_status_i (exp_status), .data_care_i (data_care), .exp_data_i (exp_data),
    .mosi_care_i (mosi_care), .exp_mosi_i (exp_mosi), .got_mosi_i (got_mosi),
    .data_i (rd_data), .tx_ready_i (tx_ready), .rx_ready_i (rx_ready),
    .tx_error_i (tx_error), .rx_error_i (rx_error), .intr_i (intr), .mosi_i (mosi),
    .mosi_tri_en_i (mosi_tri_en), .ssn_i (ssn), .tests_o (tests), .failed_o (failed),
    .errors_o (errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Word bit that travels in slot k of the frame
  function automatic int bit_pos(input int k, input logic lsb);
    return lsb ? k : `SPI_DATA_SIZE - 1 - k;
  endfunction

  task automatic host_write(input spi_word_t w);
    csn = 1'b0;
    wr = 1'b1;
    wr_data = w;
    @(negedge i_sys_clk);
    csn = 1'b1;
    wr = 1'b0;
  endtask

  task automatic host_read();
    csn = 1'b0;
    rd = 1'b1;
    @(negedge i_sys_clk);
    csn = 1'b1;
    rd = 1'b0;
  endtask

  task automatic check_now(input spi_status_t st, input logic dcare, input spi_word_t dexp,
                           input logic mcare);
    exp_status = st;
    data_care = dcare;
    exp_data = dexp;
    mosi_care = mcare;
    check = 1'b1;
    @(negedge i_sys_clk);
    check = 1'b0;
  endtask

  task automatic finish_test();
    test_done = 1'b1;
    @(negedge i_sys_clk);
    test_done = 1'b0;
  endtask

  // sel picks rx_ready, tx_ready or rx_error
  task automatic wait_for_flag(input int sel, input string what);
    int         n;
    logic [2:0] flags;
    n = 0;
    flags = {rx_error, tx_ready, rx_ready};
    while (!flags[sel] && n < WAIT_LIMIT)
    begin
      @(negedge i_sys_clk);
      n++;
      flags = {rx_error, tx_ready, rx_ready};
    end
    if (!flags[sel])
    begin
      $display("Timeout: %s never rose during %s", what, cur_name);
      timeouts++;
    end
  endtask

  // SPI master with a half sclk period of three system cycles
  task automatic spi_transfer(input stim_row_t r, output spi_word_t got);
    got = '0;
    ssn = 1'b0;
    miso = r.rx_word[bit_pos(0, r.lsb_first)];
    repeat (3) @(negedge i_sys_clk);
    for (int k = 0; k < `SPI_DATA_SIZE; k++)
    begin
      if (r.cpha)
        miso = r.rx_word[bit_pos(k, r.lsb_first)];   // Launch on the leading edge
      else
        got[bit_pos(k, r.lsb_first)] = mosi;
      sclk = ~sclk;
      repeat (3) @(negedge i_sys_clk);
      if (r.cpha)
        got[bit_pos(k, r.lsb_first)] = mosi;         // Sample on the trailing edge
      sclk = ~sclk;
      if (!r.cpha && k < `SPI_DATA_SIZE - 1)
        miso = r.rx_word[bit_pos(k + 1, r.lsb_first)];
      repeat (3) @(negedge i_sys_clk);
    end
    ssn = 1'b1;
  endtask

  // Status order is tx_ready, rx_ready, tx_error, rx_error
  task automatic run_row(input stim_row_t r);
    spi_word_t got;
    cur_name = r.name;
    cpol = r.cpol;
    cpha = r.cpha;
    lsb_first = r.lsb_first;
    sclk = r.cpol;                          // Idle level for the mode
    @(negedge i_sys_clk);
    host_write(r.tx_word);
    check_now(spi_status_t'(4'b1000), 1'b0, '0, 1'b0);
    spi_start = 1'b1;
    @(negedge i_sys_clk);
    spi_start = 1'b0;
    host_write(~r.tx_word);                 // Refused while busy
    check_now(spi_status_t'(4'b0010), 1'b0, '0, 1'b0);
    spi_transfer(r, got);
    wait_for_flag(0, "rx_ready_o");
    wait_for_flag(1, "tx_ready_o");
    exp_mosi = r.tx_word;
    got_mosi = got;
    check_now(spi_status_t'(4'b1110), 1'b1, r.rx_word, 1'b1);
    host_read();
    check_now(spi_status_t'(4'b1010), 1'b1, r.rx_word, 1'b0);
    finish_test();
  endtask

  // Two received words with no read between them
  task automatic overwrite_test();
    stim_row_t r;
    spi_word_t got;
    r = stim_rows[ROWS-1];
    r.rx_word = ~r.rx_word;                 // Differs from the word still on data_o
    cur_name = "overwrite";
    spi_transfer(r, got);
    wait_for_flag(0, "rx_ready_o");
    check_now(spi_status_t'(4'b1110), 1'b1, r.rx_word, 1'b0);
    r.rx_word = ~r.rx_word;
    spi_transfer(r, got);
    wait_for_flag(2, "rx_error_o");
    check_now(spi_status_t'(4'b1111), 1'b1, r.rx_word, 1'b0);
    host_read();
    check_now(spi_status_t'(4'b1010), 1'b1, r.rx_word, 1'b0);
    finish_test();
  endtask

  initial
  begin
    i_sys_clk = 1'b0;
    forever #2 i_sys_clk = ~i_sys_clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    i_sys_rst = 1'b1;
    csn = 1'b1;
    wr_data = '0;
    wr = 1'b0;
    rd = 1'b0;
    spi_start = 1'b0;
    cpol = 1'b0;
    cpha = 1'b0;
    lsb_first = 1'b0;
    miso = 1'b0;
    ssn = 1'b1;
    sclk = 1'b0;
    check = 1'b0;
    test_done = 1'b0;
    cur_name = "after_rst";
    exp_status = '0;
    data_care = 1'b0;
    exp_data = '0;
    mosi_care = 1'b0;
    exp_mosi = '0;
    got_mosi = '0;
    // name, cpol, cpha, lsb_first, tx word, rx word
    stim_rows[0] = '{"mode0_lsb", 1'b0, 1'b0, 1'b1, 16'hA5C3, 16'h3C5A};
    stim_rows[1] = '{"mode0_msb", 1'b0, 1'b0, 1'b0, 16'h8001, 16'h1234};
    stim_rows[2] = '{"mode1_lsb", 1'b0, 1'b1, 1'b1, 16'h0F1E, 16'hC001};
    stim_rows[3] = '{"mode1_msb", 1'b0, 1'b1, 1'b0, 16'hB00C, 16'h7E81};
    stim_rows[4] = '{"mode2_lsb", 1'b1, 1'b0, 1'b1, 16'h0000, 16'h0000};
    stim_rows[5] = '{"mode2_msb", 1'b1, 1'b0, 1'b0, 16'h0000, 16'h0000};
    stim_rows[6] = '{"mode3_lsb", 1'b1, 1'b1, 1'b1, 16'h0000, 16'h0000};
    stim_rows[7] = '{"mode3_msb", 1'b1, 1'b1, 1'b0, 16'h0000, 16'h0000};
    rng = 32'd47;
    for (int i = 4; i < ROWS; i++)
    begin
      rng = xorshift32(rng);
      stim_rows[i].tx_word = rng[`SPI_DATA_SIZE-1:0];
      rng = xorshift32(rng);
      stim_rows[i].rx_word = rng[`SPI_DATA_SIZE-1:0];
    end
    repeat (5) @(negedge i_sys_clk);
    i_sys_rst = 1'b0;
    repeat (2) @(negedge i_sys_clk);
    check_now(spi_status_t'(4'b1000), 1'b1, '0, 1'b0);
    finish_test();
    for (int i = 0; i < ROWS; i++)
      run_row(stim_rows[i]);
    overwrite_test();
    @(negedge i_sys_clk);
    $display("Summary: %0d tests, %0d failed, %0d mismatches, %0d timeouts",
             tests, failed, errors, timeouts);
    if (failed == 0 && errors == 0 && timeouts == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/spi_pkg.sv
verilog/spi_rx_shifter.sv
verilog/spi_tx_serializer.sv
verilog/spi_done_sync.sv
verilog/spi_host_regs.sv
verilog/spi_data_path.sv
dv/spi_checker.sv
dv/tb_spi_data_path.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator and run the testbench
# Pass is decided by the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_spi_data_path -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q -F -- '*** PASSED ***' \
  && echo "Simulation run ok" \
  || { echo "Simulation run not ok"; exit 1; }

/* verilog/spi_data_path.sv */
`timescale 1ns/1ps

module spi_data_path
(
  input  logic               i_sys_clk,
  input  logic               i_sys_rst,
  input  logic               csn_i,
  input  spi_pkg::spi_word_t data_i,
  input  logic               wr_i,
  input  logic               rd_i,
  input  logic               spi_start_i,
  output spi_pkg::spi_word_t data_o,
  output logic               tx_ready_o,
  output logic               rx_ready_o,
  output logic               tx_error_o,
  output logic               rx_error_o,
  input  logic               cpol_i,
  input  logic               cpha_i,
  input  logic               lsb_first_i,
  output logic               intr_o,
  output logic               mosi_o,
  input  logic               miso_i,
  input  logic               ssn_i,
  input  logic               sclk_i,
  output logic               mosi_tri_en_o
);

  import spi_pkg::*;

  spi_cfg_t    cfg;
  host_req_t   req;
  spi_status_t status;
  spi_word_t   rx_word;
  spi_word_t   tx_word;
  logic        rx_done;
  logic        rx_done_p;
  logic        tx_done;
  logic        tx_done_p;

  assign cfg = '{cpol: cpol_i, cpha: cpha_i, lsb_first: lsb_first_i};
  assign req = '{csn: csn_i, wr: wr_i, rd: rd_i, spi_start: spi_start_i};

  // sclk domain
  spi_rx_shifter rx_shifter (
    .i_sys_rst (i_sys_rst),
    .sclk_i    (sclk_i),
    .ssn_i     (ssn_i),
    .miso_i    (miso_i),
    .cfg_i     (cfg),
    .rx_word_o (rx_word),
    .rx_done_o (rx_done)
  );

  spi_tx_serializer tx_serializer (
    .i_sys_rst (i_sys_rst),
    .sclk_i    (sclk_i),
    .ssn_i     (ssn_i),
    .cfg_i     (cfg),
    .tx_word_i (tx_word),
    .mosi_o    (mosi_o),
    .tx_done_o (tx_done)
  );

  spi_done_sync rx_sync (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .done_i    (rx_done),
    .done_p_o  (rx_done_p)
  );

  spi_done_sync tx_sync (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .done_i    (tx_done),
    .done_p_o  (tx_done_p)
  );

  spi_host_regs host_regs (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .req_i       (req),
    .data_i      (data_i),
    .rx_word_i   (rx_word),
    .rx_done_p_i (rx_done_p),
    .tx_done_p_i (tx_done_p),
    .tx_word_o   (tx_word),
    .data_o      (data_o),
    .status_o    (status),
    .intr_o      (intr_o)
  );

  assign tx_ready_o    = status.tx_ready;
  assign rx_ready_o    = status.rx_ready;
  assign tx_error_o    = status.tx_error;
  assign rx_error_o    = status.rx_error;
  assign mosi_tri_en_o = ssn_i;   // Output driver off while deselected

endmodule

/* verilog/spi_done_sync.sv */
`timescale 1ns/1ps

module spi_done_sync
(
  input  logic i_sys_clk,
  input  logic i_sys_rst,
  input  logic done_i,     // Level from the sclk domain
  output logic done_p_o    // One system clock pulse
);

  // Bit 0 is the first synchroniser stage
  logic [2:0] sync_q;

  always_ff @(posedge i_sys_clk or posedge i_sys_rst)
  begin
    if (i_sys_rst)
      sync_q <= '0;
    else
      sync_q <= {sync_q[1:0], done_i};
  end

  // Rising edge seen between stages 2 and 3
  assign done_p_o = sync_q[1] & ~sync_q[2];

  assert property (@(posedge i_sys_clk) disable iff (i_sys_rst)
    done_p_o |=> !done_p_o)
    else $error("done pulse longer than one cycle");

endmodule

/* verilog/spi_host_regs.sv */
`timescale 1ns/1ps

module spi_host_regs
(
  input  logic                 i_sys_clk,
  input  logic                 i_sys_rst,
  input  spi_pkg::host_req_t   req_i,
  input  spi_pkg::spi_word_t   data_i,
  input  spi_pkg::spi_word_t   rx_word_i,
  input  logic                 rx_done_p_i,
  input  logic                 tx_done_p_i,
  output spi_pkg::spi_word_t   tx_word_o,
  output spi_pkg::spi_word_t   data_o,
  output spi_pkg::spi_status_t status_o,
  output logic                 intr_o
);

  import spi_pkg::*;

  spi_word_t tx_latch;
  spi_word_t tx_word_q;
  spi_word_t rx_data_q;
  logic      wr_en;
  logic      rd_en;
  logic      tx_ready_q;
  logic      rx_ready_q;
  logic      tx_error_q;
  logic      rx_error_q;
  logic      intr_q;

  assign wr_en = req_i.wr & ~req_i.csn;
  assign rd_en = req_i.rd & ~req_i.csn;

  // Host word is taken only while the transmitter is idle
  always_ff @(posedge i_sys_clk)
  begin
    if (wr_en && tx_ready_q)
      tx_latch <= data_i;
    tx_word_q <= tx_latch;    // Re-registered copy for the serializer
  end

  always_ff @(posedge i_sys_clk or posedge i_sys_rst)
  begin
    if (i_sys_rst)
    begin
      rx_data_q  <= '0;
      rx_ready_q <= 1'b0;
      rx_error_q <= 1'b0;
    end
    else if (rx_done_p_i)
    begin
      rx_data_q  <= rx_word_i;
      rx_ready_q <= 1'b1;
      if (rx_ready_q)
        rx_error_q <= 1'b1;   // Previous word never read
    end
    else if (rd_en)
    begin
      rx_ready_q <= 1'b0;
      rx_error_q <= 1'b0;
    end
  end

  always_ff @(posedge i_sys_clk or posedge i_sys_rst)
  begin
    if (i_sys_rst)
    begin
      tx_ready_q <= 1'b1;
      tx_error_q <= 1'b0;
    end
    else
    begin
      if (req_i.spi_start)
        tx_ready_q <= 1'b0;
      else if (tx_done_p_i)
        tx_ready_q <= 1'b1;

      if (wr_en)
        tx_error_q <= ~tx_ready_q;  // Write while busy
    end
  end

  // Sticky until reset
  always_ff @(posedge i_sys_clk or posedge i_sys_rst)
  begin
    if (i_sys_rst)
      intr_q <= 1'b0;
    else if (tx_ready_q | rx_ready_q | tx_error_q | rx_error_q)
      intr_q <= 1'b1;
  end

  assign tx_word_o = tx_word_q;
  assign data_o    = rx_data_q;
  assign intr_o    = intr_q;
  assign status_o  = '{tx_ready: tx_ready_q, rx_ready: rx_ready_q,
                       tx_error: tx_error_q, rx_error: rx_error_q};

  assert property (@(posedge i_sys_clk) disable iff (i_sys_rst)
    $rose(tx_error_q) |-> $past(wr_en))
    else $error("tx_error set without a host write");

endmodule

/* verilog/spi_pkg.sv */
`include "spi_settings.svh"

package spi_pkg;

  typedef logic [`SPI_DATA_SIZE-1:0] spi_word_t;
  typedef logic [`SPI_CNT_W-1:0]     spi_cnt_t;

  // SPI mode and bit order
  typedef struct packed {
    logic cpol;
    logic cpha;
    logic lsb_first;
  } spi_cfg_t;

  // Host bus request lines
  typedef struct packed {
    logic csn;        // Active low select
    logic wr;
    logic rd;
    logic spi_start;
  } host_req_t;

  typedef struct packed {
    logic tx_ready;
    logic rx_ready;
    logic tx_error;
    logic rx_error;
  } spi_status_t;

  // Modes 0 and 3 sample on the rising sclk edge
  function automatic logic sample_on_rise(spi_cfg_t cfg);
    return cfg.cpol == cfg.cpha;
  endfunction

endpackage

/* verilog/spi_rx_shifter.sv */
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_rx_shifter
(
  input  logic               i_sys_rst,
  input  logic               sclk_i,
  input  logic               ssn_i,
  input  logic               miso_i,
  input  spi_pkg::spi_cfg_t  cfg_i,
  output spi_pkg::spi_word_t rx_word_o,
  output logic               rx_done_o
);

  import spi_pkg::*;

  localparam spi_cnt_t LAST_BIT = spi_cnt_t'(`SPI_DATA_SIZE - 1);

  spi_word_t pos_shift;
  spi_word_t neg_shift;
  spi_cnt_t  pos_cnt;
  spi_cnt_t  neg_cnt;
  logic      pos_done;
  logic      neg_done;
  logic      pos_en;
  logic      neg_en;

  // New bit enters at the top for LSB first, at the bottom otherwise
  function automatic spi_word_t shift_in(spi_word_t cur, logic bit_in, logic lsb_first);
    if (lsb_first)
      return {bit_in, cur[`SPI_DATA_SIZE-1:1]};
    else
      return {cur[`SPI_DATA_SIZE-2:0], bit_in};
  endfunction

  assign pos_en = ~ssn_i & sample_on_rise(cfg_i);   // Modes 0 and 3
  assign neg_en = ~ssn_i & ~sample_on_rise(cfg_i);  // Modes 1 and 2

  always_ff @(posedge sclk_i)
  begin
    if (pos_en)
      pos_shift <= shift_in(pos_shift, miso_i, cfg_i.lsb_first);
  end

  always_ff @(negedge sclk_i)
  begin
    if (neg_en)
      neg_shift <= shift_in(neg_shift, miso_i, cfg_i.lsb_first);
  end

  // Done rises with the last bit and drops on the next counted edge
  always_ff @(posedge sclk_i or posedge i_sys_rst)
  begin
    if (i_sys_rst)
    begin
      pos_cnt  <= '0;
      pos_done <= 1'b0;
    end
    else if (pos_en)
    begin
      pos_done <= (pos_cnt == LAST_BIT);
      pos_cnt  <= (pos_cnt == LAST_BIT) ? '0 : pos_cnt + 1'b1;
    end
  end

  always_ff @(negedge sclk_i or posedge i_sys_rst)
  begin
    if (i_sys_rst)
    begin
      neg_cnt  <= '0;
      neg_done <= 1'b0;
    end
    else if (neg_en)
    begin
      neg_done <= (neg_cnt == LAST_BIT);
      neg_cnt  <= (neg_cnt == LAST_BIT) ? '0 : neg_cnt + 1'b1;
    end
  end

  assign rx_word_o = sample_on_rise(cfg_i) ? pos_shift : neg_shift;
  assign rx_done_o = sample_on_rise(cfg_i) ? pos_done  : neg_done;

  assert property (@(posedge sclk_i) disable iff (i_sys_rst)
    (pos_cnt <= LAST_BIT) && (neg_cnt <= LAST_BIT))
    else $error("rx bit counter past last bit");

endmodule

/* verilog/spi_settings.svh */
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Width of one SPI word in bits
`define SPI_DATA_SIZE 16

// Bit counter width
// Must be able to hold SPI_DATA_SIZE-1
`define SPI_CNT_W 5

`endif

/* verilog/spi_tx_serializer.sv */
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_tx_serializer
(
  input  logic               i_sys_rst,
  input  logic               sclk_i,
  input  logic               ssn_i,
  input  spi_pkg::spi_cfg_t  cfg_i,
  input  spi_pkg::spi_word_t tx_word_i,
  output logic               mosi_o,
  output logic               tx_done_o
);

  import spi_pkg::*;

  localparam spi_cnt_t LAST_BIT = spi_cnt_t'(`SPI_DATA_SIZE - 1);

  spi_cnt_t pos_cnt;
  spi_cnt_t neg_cnt;
  logic     pos_done;
  logic     neg_done;
  logic     pos_en;
  logic     neg_en;
  logic     mosi_pos_q;   // Launch register for mode 1
  logic     mosi_neg_q;   // Launch register for mode 3

  // Bit of the word that goes out at count cnt
  function automatic logic tx_bit(spi_word_t word, spi_cnt_t cnt, logic lsb_first);
    spi_cnt_t  idx;
    spi_word_t shifted;
    idx     = lsb_first ? cnt : LAST_BIT - cnt;
    shifted = word >> idx;
    return shifted[0];
  endfunction

  // Counters run on the edge opposite the sampling edge
  assign pos_en = ~ssn_i & ~sample_on_rise(cfg_i);  // Modes 1 and 2
  assign neg_en = ~ssn_i & sample_on_rise(cfg_i);   // Modes 0 and 3

  always_ff @(posedge sclk_i or posedge i_sys_rst)
  begin
    if (i_sys_rst)
    begin
      pos_cnt  <= '0;
      pos_done <= 1'b0;
    end
    else if (pos_en)
    begin
      pos_done <= (pos_cnt == LAST_BIT);
      pos_cnt  <= (pos_cnt == LAST_BIT) ? '0 : pos_cnt + 1'b1;
    end
  end

  always_ff @(negedge sclk_i or posedge i_sys_rst)
  begin
    if (i_sys_rst)
    begin
      neg_cnt  <= '0;
      neg_done <= 1'b0;
    end
    else if (neg_en)
    begin
      neg_done <= (neg_cnt == LAST_BIT);
      neg_cnt  <= (neg_cnt == LAST_BIT) ? '0 : neg_cnt + 1'b1;
    end
  end

  // With CPHA=1 the bit is launched on the leading edge
  always_ff @(posedge sclk_i or posedge i_sys_rst)
  begin
    if (i_sys_rst)
      mosi_pos_q <= 1'b1;
    else
      mosi_pos_q <= tx_bit(tx_word_i, pos_cnt, cfg_i.lsb_first);
  end

  always_ff @(negedge sclk_i or posedge i_sys_rst)
  begin
    if (i_sys_rst)
      mosi_neg_q <= 1'b1;
    else
      mosi_neg_q <= tx_bit(tx_word_i, neg_cnt, cfg_i.lsb_first);
  end

  always_comb
  begin
    if (ssn_i)
      mosi_o = 1'b0;      // Quiet while deselected
    else
      case ({cfg_i.cpol, cfg_i.cpha})
        2'b00:   mosi_o = tx_bit(tx_word_i, neg_cnt, cfg_i.lsb_first);
        2'b01:   mosi_o = mosi_pos_q;
        2'b10:   mosi_o = tx_bit(tx_word_i, pos_cnt, cfg_i.lsb_first);
        default: mosi_o = mosi_neg_q;
      endcase
  end

  assign tx_done_o = sample_on_rise(cfg_i) ? neg_done : pos_done;

endmodule
